//--- flist.f
source/cache_pkg.sv
source/cache_ctrl.sv
source/cache_tag_array.sv
source/cache_data_array.sv
source/cache_lru.sv
source/cache_top.sv
sim/mem_model.sv
sim/tb_cache.sv

//--- sim/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
  parameter int DEPTH_BITS = 10
) (
  input  logic               clk,
  input  logic               mrden,
  input  cache_pkg::addr_t   mrdaddress,
  input  logic               mwren,
  input  cache_pkg::addr_t   mwraddress,
  input  cache_pkg::block_t  mdout,
  output cache_pkg::block_t  mq
);
  import cache_pkg::*;

  localparam int DEPTH = 1 << DEPTH_BITS;

  block_t  blocks  [DEPTH];
  addr_t   owner   [DEPTH];  // Full block address held in the slot
  logic    written [DEPTH];

  function automatic int slot(input addr_t blk_addr);
    return int'(blk_addr[OFFSET_WIDTH +: DEPTH_BITS]);
  endfunction

  // Unwritten blocks hold their own address in each word
  function automatic block_t read_block(input addr_t blk_addr);
    int s;
    s = slot(blk_addr);
    if (written[s] && owner[s] == blk_addr) begin
      return blocks[s];
    end
    return {blk_addr + addr_t'(4), blk_addr};
  endfunction

  initial begin
    mq = '0;
    for (int i = 0; i < DEPTH; i++) begin
      written[i] = 1'b0;
    end
  end

  always @(posedge clk) begin
    if (mrden) begin
      mq <= read_block(mrdaddress);  // One cycle read latency
    end
    if (mwren) begin
      blocks[slot(mwraddress)]  <= mdout;
      owner[slot(mwraddress)]   <= mwraddress;
      written[slot(mwraddress)] <= 1'b1;
    end
  end

endmodule

//--- sim/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;
  import cache_pkg::*;

  localparam int INDEX_WIDTH = 4;
  localparam int NUM_SETS    = 1 << INDEX_WIDTH;
  localparam int NUM_REQ     = 400;
  localparam int MAX_CYCLES  = NUM_REQ * 8 + 100;
  localparam int REQ_LIMIT   = 12;  // Edges allowed per request

  logic    clk;
  logic    reset_n;
  addr_t   address;
  word_t   din;
  logic    rden;
  logic    wren;
  block_t  mq;
  logic    hit_miss;
  word_t   q;
  logic    mrden;
  addr_t   mrdaddress;
  logic    mwren;
  addr_t   mwraddress;
  block_t  mdout;

  // Reference model: flat words plus a mirror of each set
  word_t   ref_mem [256];
  logic    m_valid [NUM_SETS][NUM_WAYS];
  logic    m_dirty [NUM_SETS][NUM_WAYS];
  int      m_tag   [NUM_SETS][NUM_WAYS];
  age_t    m_age   [NUM_SETS][NUM_WAYS];

  int      errors      = 0;
  int      hits        = 0;
  int      misses      = 0;
  int      write_backs = 0;
  int      cycle_count = 0;

  cache_top #(.INDEX_WIDTH(INDEX_WIDTH)) DUT (
    .clk(clk), .reset_n(reset_n), .address(address), .din(din), .rden(rden), .wren(wren),
    .mq(mq), .hit_miss(hit_miss), .q(q), .mrden(mrden), .mrdaddress(mrdaddress),
    .mwren(mwren), .mwraddress(mwraddress), .mdout(mdout)
  );

  mem_model u_mem (
    .clk(clk), .mrden(mrden), .mrdaddress(mrdaddress), .mwren(mwren),
    .mwraddress(mwraddress), .mdout(mdout), .mq(mq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("requests=%0d hits=%0d misses=%0d write_backs=%0d errors=%0d",
               NUM_REQ, hits, misses, write_backs, errors);
      $display("Test FAILED");
      $finish;
    end
  end

  // Lowest invalid way first, else the least recent one
  function automatic int pick_victim(input int idx);
    int v;
    v = -1;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!m_valid[idx][w] && v < 0) v = w;
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (v < 0 && m_age[idx][w] == 2'd3) v = w;
    end
    return v;
  endfunction

  task automatic age_update(input int idx, input int way);
    age_t old;
    old = m_age[idx][way];
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (w == way) m_age[idx][w] = 2'd0;
      else if (m_age[idx][w] <= old) m_age[idx][w] = m_age[idx][w] + 2'd1;
    end
  endtask

  task automatic run_request(input int n);
    int      tag;
    int      idx;
    int      way;
    int      wi;
    int      wb_wi;
    int      exp_edges;
    int      edges;
    int      rd_pulses;
    int      wr_pulses;
    logic    is_wr;
    logic    hit_pred;
    logic    dirty_pred;
    addr_t   addr;
    addr_t   blk;
    addr_t   wb_addr;
    block_t  wb_data;
    word_t   data;
    tag   = $urandom % 8;
    idx   = $urandom % 4;
    addr  = addr_t'((tag << (OFFSET_WIDTH + INDEX_WIDTH)) | (idx << OFFSET_WIDTH)
                    | (($urandom % 2) << 2));
    blk   = addr_t'((tag << (OFFSET_WIDTH + INDEX_WIDTH)) | (idx << OFFSET_WIDTH));
    wi    = int'(addr >> 2);
    is_wr = $urandom % 2;
    data  = $urandom;
    hit_pred   = 1'b0;
    dirty_pred = 1'b0;
    way        = 0;
    wb_addr    = '0;
    wb_data    = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!hit_pred && m_valid[idx][w] && m_tag[idx][w] == tag) begin
        hit_pred = 1'b1;
        way      = w;
      end
    end
    if (!hit_pred) begin
      way        = pick_victim(idx);
      dirty_pred = m_valid[idx][way] && m_dirty[idx][way];
      wb_addr    = addr_t'((m_tag[idx][way] << (OFFSET_WIDTH + INDEX_WIDTH))
                           | (idx << OFFSET_WIDTH));
      wb_wi      = int'(wb_addr >> 2);
      wb_data    = {ref_mem[wb_wi + 1], ref_mem[wb_wi]};
    end
    exp_edges = hit_pred ? 1 : (dirty_pred ? 7 : 6);

    address = addr;
    din     = data;
    rden    = !is_wr;
    wren    = is_wr;
    edges     = 0;
    rd_pulses = 0;
    wr_pulses = 0;
    // hit_miss of the previous request may still be high here
    do begin
      @(posedge clk);
      #1;
      edges++;
      if (mwren === 1'b1) begin
        wr_pulses++;
        if (mwraddress !== wb_addr) begin
          errors++;
          $display("mismatch write-back address req %0d expected %h actual %h",
                   n, wb_addr, mwraddress);
        end
        if (mdout !== wb_data) begin
          errors++;
          $display("mismatch write-back data req %0d expected %h actual %h", n, wb_data, mdout);
        end
      end
      if (mrden === 1'b1) begin
        rd_pulses++;
        if (mrdaddress !== blk) begin
          errors++;
          $display("mismatch fetch address req %0d expected %h actual %h", n, blk, mrdaddress);
        end
      end
    end while (hit_miss !== 1'b1 && edges < REQ_LIMIT);

    if (hit_miss !== 1'b1) begin
      errors++;
      $display("req %0d got no hit_miss within %0d cycles", n, REQ_LIMIT);
    end else if (edges != exp_edges) begin
      errors++;
      $display("mismatch latency req %0d expected %0d actual %0d", n, exp_edges, edges);
    end
    if (!is_wr && q !== ref_mem[wi]) begin
      errors++;
      $display("mismatch read data req %0d expected %h actual %h", n, ref_mem[wi], q);
    end
    if (rd_pulses != (hit_pred ? 0 : 1)) begin
      errors++;
      $display("mismatch fetch count req %0d expected %0d actual %0d",
               n, hit_pred ? 0 : 1, rd_pulses);
    end
    if (wr_pulses != (dirty_pred ? 1 : 0)) begin
      errors++;
      $display("mismatch write-back count req %0d expected %0d actual %0d",
               n, dirty_pred ? 1 : 0, wr_pulses);
    end

    // Mirror follows the refill and then the hit
    if (hit_pred) begin
      hits++;
    end else begin
      misses++;
      if (dirty_pred) write_backs++;
      m_tag[idx][way]   = tag;
      m_valid[idx][way] = 1'b1;
      m_dirty[idx][way] = 1'b0;
      age_update(idx, way);
    end
    age_update(idx, way);
    if (is_wr) begin
      m_dirty[idx][way] = 1'b1;
      ref_mem[wi]       = data;
    end
  endtask

  initial begin
    void'($urandom(22));
    reset_n = 1'b0;
    address = '0;
    din     = '0;
    rden    = 1'b0;
    wren    = 1'b0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = word_t'(i * 4);  // Default word equals its own address
    end
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w]   = 0;
      end
      m_age[s][0] = 2'd0;
      m_age[s][1] = 2'd1;
      m_age[s][2] = 2'd3;
      m_age[s][3] = 2'd2;
    end
    repeat (8) @(posedge clk);
    #1;
    if (hit_miss !== 1'b0 || mrden !== 1'b0 || mwren !== 1'b0) begin
      errors++;
      $display("hit_miss, mrden or mwren not low during reset");
    end
    reset_n = 1'b1;

    for (int n = 0; n < NUM_REQ; n++) begin
      run_request(n);
      if ($urandom % 4 == 0) begin
        rden = 1'b0;  // Idle cycle
        wren = 1'b0;
        @(posedge clk);
        #1;
        if (hit_miss !== 1'b0) begin
          errors++;
          $display("hit_miss high after a cycle without a request");
        end
      end
    end

    $display("requests=%0d hits=%0d misses=%0d write_backs=%0d errors=%0d",
             NUM_REQ, hits, misses, write_backs, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- source/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
  parameter int INDEX_WIDTH = 4,
  localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  cache_pkg::addr_t      address,
  input  cache_pkg::word_t      din,
  input  logic                  rden,
  input  logic                  wren,
  input  logic                  hit,
  input  cache_pkg::way_t       hit_way,
  input  cache_pkg::word_t      rd_word,
  input  cache_pkg::way_t       victim_way,
  input  logic [TAG_WIDTH-1:0]  victim_tag,
  input  logic                  victim_dirty,
  input  cache_pkg::block_t     victim_block,
  input  cache_pkg::block_t     mq,
  output logic                  hit_miss,
  output cache_pkg::word_t      q,
  output logic                  mrden,
  output cache_pkg::addr_t      mrdaddress,
  output logic                  mwren,
  output cache_pkg::addr_t      mwraddress,
  output cache_pkg::block_t     mdout,
  output logic                  word_write,
  output logic                  touch,
  output logic                  fill,
  output cache_pkg::way_t       victim_sel,
  output cache_pkg::block_t     fill_block,
  output cache_pkg::word_t      wr_word
);
  import cache_pkg::*;

  cache_state_e            state;
  logic                    req;
  logic                    idle_hit;
  logic [INDEX_WIDTH-1:0]  index;

  assign req      = rden | wren;
  assign idle_hit = (state == IDLE) && req && hit;
  assign index    = address[OFFSET_WIDTH +: INDEX_WIDTH];

  // Array strobes act on the same edge that registers hit_miss
  assign touch      = idle_hit;
  assign word_write = idle_hit && wren;
  assign wr_word    = din;

  // mq holds the fetched block throughout REFILL
  assign fill       = (state == REFILL);
  assign fill_block = mq;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= IDLE;
      hit_miss   <= 1'b0;
      mrden      <= 1'b0;
      mwren      <= 1'b0;
      victim_sel <= '0;
    end else begin
      hit_miss <= 1'b0;  // Strobes default low
      mrden    <= 1'b0;
      mwren    <= 1'b0;
      case (state)
        IDLE: begin
          if (idle_hit) begin
            hit_miss <= 1'b1;
          end else if (req) begin
            // Victim taken with the miss so its dirty bit is visible in VICTIM
            victim_sel <= victim_way;
            state      <= VICTIM;
          end
        end
        VICTIM: begin
          state <= victim_dirty ? WRITE_BACK : FETCH;
        end
        WRITE_BACK: begin
          mwren <= 1'b1;
          state <= FETCH;
        end
        FETCH: begin
          mrden <= 1'b1;
          state <= FETCH_WAIT;
        end
        FETCH_WAIT: begin
          state <= REFILL;  // Memory registers the read here
        end
        REFILL: begin
          state <= IDLE;    // Request still held, hit follows
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (idle_hit && rden) begin
      q <= rd_word;
    end
    if (state == WRITE_BACK) begin
      mdout      <= victim_block;
      mwraddress <= {victim_tag, index, {OFFSET_WIDTH{1'b0}}};
    end
    if (state == FETCH) begin
      mrdaddress <= {address[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    end
  end

endmodule

//--- source/cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array #(
  parameter int INDEX_WIDTH = 4
) (
  input  logic               clk,
  input  cache_pkg::addr_t   address,
  input  cache_pkg::way_t    hit_way,
  input  cache_pkg::way_t    victim_sel,
  input  logic               word_write,
  input  cache_pkg::word_t   wr_word,
  input  logic               fill,
  input  cache_pkg::block_t  fill_block,
  output cache_pkg::word_t   rd_word,
  output cache_pkg::block_t  victim_block
);
  import cache_pkg::*;

  localparam int NUM_SETS = 1 << INDEX_WIDTH;

  block_t                  blocks [NUM_SETS][NUM_WAYS];
  logic [INDEX_WIDTH-1:0]  index;
  logic                    word_sel;   // 1 for the upper word
  block_t                  hit_block;

  assign index     = address[OFFSET_WIDTH +: INDEX_WIDTH];
  assign word_sel  = address[WORD_SEL_BIT];
  assign hit_block = blocks[index][hit_way];

  assign rd_word      = word_sel ? hit_block[WORD_WIDTH +: WORD_WIDTH]
                                 : hit_block[0 +: WORD_WIDTH];
  assign victim_block = blocks[index][victim_sel];

  always_ff @(posedge clk) begin
    if (fill) begin
      blocks[index][victim_sel] <= fill_block;  // Whole line
    end else if (word_write) begin
      if (word_sel) begin
        blocks[index][hit_way][WORD_WIDTH +: WORD_WIDTH] <= wr_word;
      end else begin
        blocks[index][hit_way][0 +: WORD_WIDTH] <= wr_word;
      end
    end
  end

endmodule

//--- source/cache_lru.sv
`timescale 1ns/1ps

module cache_lru #(
  parameter int INDEX_WIDTH = 4
) (
  input  logic                           clk,
  input  logic                           reset_n,
  input  cache_pkg::addr_t               address,
  input  logic [cache_pkg::NUM_WAYS-1:0] valid_bits,
  input  cache_pkg::way_t                hit_way,
  input  cache_pkg::way_t                victim_sel,
  input  logic                           touch,
  input  logic                           fill,
  output cache_pkg::way_t                victim_way
);
  import cache_pkg::*;

  localparam int NUM_SETS = 1 << INDEX_WIDTH;

  // Starting order per set, a permutation of 0..3
  localparam age_t INIT_AGE [NUM_WAYS] = '{2'd0, 2'd1, 2'd3, 2'd2};

  age_t                    ages [NUM_SETS][NUM_WAYS];
  logic [INDEX_WIDTH-1:0]  index;
  logic                    upd;
  way_t                    upd_way;
  age_t                    upd_age;

  assign index   = address[OFFSET_WIDTH +: INDEX_WIDTH];
  assign upd     = touch | fill;
  assign upd_way = fill ? victim_sel : hit_way;
  assign upd_age = ages[index][upd_way];

  // Lowest invalid way wins, otherwise the oldest
  always_comb begin
    victim_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (ages[index][w] == 2'd3) begin
        victim_way = way_t'(w);
      end
    end
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_bits[w]) begin
        victim_way = way_t'(w);
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          ages[s][w] <= INIT_AGE[w];
        end
      end
    end else if (upd) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (way_t'(w) == upd_way) begin
          ages[index][w] <= 2'd0;  // Now most recent
        end else if (ages[index][w] <= upd_age) begin
          ages[index][w] <= ages[index][w] + 2'd1;
        end
      end
    end
  end

endmodule

//--- source/cache_pkg.sv
package cache_pkg;

  // Address and data widths
  localparam int ADDR_WIDTH   = 32;
  localparam int WORD_WIDTH   = 32;
  localparam int BLOCK_WIDTH  = 64;  // Two words per line
  localparam int OFFSET_WIDTH = 3;

  // Offset bit that picks the word inside a block
  localparam int WORD_SEL_BIT = 2;

  // Fixed at four because the age encoding relies on it
  localparam int NUM_WAYS = 4;

  typedef logic [ADDR_WIDTH-1:0]  addr_t;
  typedef logic [WORD_WIDTH-1:0]  word_t;
  typedef logic [BLOCK_WIDTH-1:0] block_t;
  typedef logic [1:0]             way_t;

  // 0 is most recent, 3 is least recent
  typedef logic [1:0]             age_t;

  // Miss handling sequence of the controller
  typedef enum logic [2:0] {
    IDLE,        // Serves hits, detects misses
    VICTIM,      // Victim known, dirty check
    WRITE_BACK,  // Dirty line out to memory
    FETCH,       // Block read request
    FETCH_WAIT,  // Memory read latency
    REFILL       // Line written from mq
  } cache_state_e;

endpackage

//--- source/cache_tag_array.sv
`timescale 1ns/1ps

module cache_tag_array #(
  parameter int INDEX_WIDTH = 4,
  localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
) (
  input  logic                           clk,
  input  logic                           reset_n,
  input  cache_pkg::addr_t               address,
  input  cache_pkg::way_t                victim_sel,
  input  logic                           word_write,
  input  logic                           fill,
  output logic                           hit,
  output cache_pkg::way_t                hit_way,
  output logic [cache_pkg::NUM_WAYS-1:0] valid_bits,  // Addressed set
  output logic [TAG_WIDTH-1:0]           victim_tag,
  output logic                           victim_dirty
);
  import cache_pkg::*;

  localparam int NUM_SETS = 1 << INDEX_WIDTH;

  logic [NUM_WAYS-1:0]     valid [NUM_SETS];
  logic [NUM_WAYS-1:0]     dirty [NUM_SETS];
  logic [TAG_WIDTH-1:0]    tags  [NUM_SETS][NUM_WAYS];
  logic [INDEX_WIDTH-1:0]  index;
  logic [TAG_WIDTH-1:0]    addr_tag;
  logic [NUM_WAYS-1:0]     way_match;

  assign index    = address[OFFSET_WIDTH +: INDEX_WIDTH];
  assign addr_tag = address[ADDR_WIDTH-1 -: TAG_WIDTH];

  // All four ways compared at once
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_match[w] = valid[index][w] && (tags[index][w] == addr_tag);
    end
  end

  assign hit = |way_match;

  always_comb begin
    hit_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (way_match[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign valid_bits   = valid[index];
  assign victim_tag   = tags[index][victim_sel];
  assign victim_dirty = dirty[index][victim_sel];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid[s] <= '0;
        dirty[s] <= '0;
      end
    end else if (fill) begin
      valid[index][victim_sel] <= 1'b1;
      dirty[index][victim_sel] <= 1'b0;  // Fresh from memory
    end else if (word_write) begin
      dirty[index][hit_way] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tags[index][victim_sel] <= addr_tag;
    end
  end

endmodule

//--- source/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
  parameter int INDEX_WIDTH = 4,
  localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
) (
  input  logic               clk,
  input  logic               reset_n,
  input  cache_pkg::addr_t   address,     // CPU request
  input  cache_pkg::word_t   din,
  input  logic               rden,
  input  logic               wren,
  input  cache_pkg::block_t  mq,          // Memory read data
  output logic               hit_miss,
  output cache_pkg::word_t   q,
  output logic               mrden,
  output cache_pkg::addr_t   mrdaddress,
  output logic               mwren,
  output cache_pkg::addr_t   mwraddress,
  output cache_pkg::block_t  mdout
);
  import cache_pkg::*;

  logic                  hit;
  way_t                  hit_way;
  word_t                 rd_word;
  way_t                  victim_way;
  way_t                  victim_sel;
  logic [TAG_WIDTH-1:0]  victim_tag;
  logic                  victim_dirty;
  block_t                victim_block;
  logic [NUM_WAYS-1:0]   valid_bits;
  logic                  word_write;
  logic                  touch;
  logic                  fill;
  block_t                fill_block;
  word_t                 wr_word;

  cache_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) u_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .address      (address),
    .din          (din),
    .rden         (rden),
    .wren         (wren),
    .hit          (hit),
    .hit_way      (hit_way),
    .rd_word      (rd_word),
    .victim_way   (victim_way),
    .victim_tag   (victim_tag),
    .victim_dirty (victim_dirty),
    .victim_block (victim_block),
    .mq           (mq),
    .hit_miss     (hit_miss),
    .q            (q),
    .mrden        (mrden),
    .mrdaddress   (mrdaddress),
    .mwren        (mwren),
    .mwraddress   (mwraddress),
    .mdout        (mdout),
    .word_write   (word_write),
    .touch        (touch),
    .fill         (fill),
    .victim_sel   (victim_sel),
    .fill_block   (fill_block),
    .wr_word      (wr_word)
  );

  cache_tag_array #(.INDEX_WIDTH(INDEX_WIDTH)) u_tags (
    .clk          (clk),
    .reset_n      (reset_n),
    .address      (address),
    .victim_sel   (victim_sel),
    .word_write   (word_write),
    .fill         (fill),
    .hit          (hit),
    .hit_way      (hit_way),
    .valid_bits   (valid_bits),
    .victim_tag   (victim_tag),
    .victim_dirty (victim_dirty)
  );

  cache_data_array #(.INDEX_WIDTH(INDEX_WIDTH)) u_data (
    .clk          (clk),
    .address      (address),
    .hit_way      (hit_way),
    .victim_sel   (victim_sel),
    .word_write   (word_write),
    .wr_word      (wr_word),
    .fill         (fill),
    .fill_block   (fill_block),
    .rd_word      (rd_word),
    .victim_block (victim_block)
  );

  cache_lru #(.INDEX_WIDTH(INDEX_WIDTH)) u_lru (
    .clk          (clk),
    .reset_n      (reset_n),
    .address      (address),
    .valid_bits   (valid_bits),
    .hit_way      (hit_way),
    .victim_sel   (victim_sel),
    .touch        (touch),
    .fill         (fill),
    .victim_way   (victim_way)
  );

endmodule
